// ==== cpe.f ====
+incdir+include
design/cpe_pkg.sv
design/inst_mem.sv
design/pe_control.sv
design/data_mem.sv
design/complex_alu.sv
design/pe.sv
testbench/pe_assertions.sv
testbench/pe_tb.sv

// ==== design/complex_alu.sv ====
`timescale 1ns/1ps
`include "cpe_consts.svh"

module complex_alu (
    input  logic             clk,
    input  logic             arst_n,
    input  cpe_pkg::alu_op_t op,
    input  cpe_pkg::cplx_t   din_1,
    input  cpe_pkg::cplx_t   din_2,
    output cpe_pkg::cplx_t   dout
);
    import cpe_pkg::*;

    // full product width of two halves
    localparam int PROD_W = 2 * `DATA_WIDTH;

    // stage one registers
    logic signed [PROD_W-1:0] rr_q;
    logic signed [PROD_W-1:0] ii_q;
    logic signed [PROD_W-1:0] ri_q;
    logic signed [PROD_W-1:0] ir_q;
    cplx_t                    sum_q;
    cplx_t                    diff_q;
    cplx_t                    pass_q;
    alu_op_t                  op_q;

    // stage two combine
    logic signed [PROD_W-1:0] mul_re_full;
    logic signed [PROD_W-1:0] mul_im_full;
    cplx_t                    res;

    ////////////////////////////////////////
    // stage one
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rr_q   <= '0;
            ii_q   <= '0;
            ri_q   <= '0;
            ir_q   <= '0;
            sum_q  <= '0;
            diff_q <= '0;
            pass_q <= '0;
            op_q   <= op_add;
        end else begin
            // four partial products, sign extended first
            rr_q      <= PROD_W'(din_1.re) * PROD_W'(din_2.re);
            ii_q      <= PROD_W'(din_1.im) * PROD_W'(din_2.im);
            ri_q      <= PROD_W'(din_1.re) * PROD_W'(din_2.im);
            ir_q      <= PROD_W'(din_1.im) * PROD_W'(din_2.re);
            // per half, wraps at DATA_WIDTH
            sum_q.re  <= din_1.re + din_2.re;
            sum_q.im  <= din_1.im + din_2.im;
            diff_q.re <= din_1.re - din_2.re;
            diff_q.im <= din_1.im - din_2.im;
            pass_q    <= din_1;
            op_q      <= op;
        end
    end

    ////////////////////////////////////////
    // stage two
    ////////////////////////////////////////

    // realign the fraction, sign kept
    assign mul_re_full = (rr_q - ii_q) >>> `FRAC_BITS;
    assign mul_im_full = (ri_q + ir_q) >>> `FRAC_BITS;

    always_comb begin
        case (op_q)
            op_add: res = sum_q;
            op_sub: res = diff_q;
            op_mul: begin
                // low half only, wraps
                res.re = mul_re_full[`DATA_WIDTH-1:0];
                res.im = mul_im_full[`DATA_WIDTH-1:0];
            end
            // op_mov, src0 through
            default: res = pass_q;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dout <= '0;
        end else begin
            dout <= res;
        end
    end

endmodule

// ==== design/cpe_pkg.sv ====
`include "cpe_consts.svh"

package cpe_pkg;

    ////////////////////////////////////////
    // complex sample
    ////////////////////////////////////////

    // re in the upper half, im below
    typedef struct packed {
        logic signed [`DATA_WIDTH-1:0] re;
        logic signed [`DATA_WIDTH-1:0] im;
    } cplx_t;

    ////////////////////////////////////////
    // instruction word
    ////////////////////////////////////////

    // compact alu opcode
    typedef enum logic [1:0] {
        op_add = 2'd0,
        op_sub = 2'd1,
        op_mul = 2'd2,
        op_mov = 2'd3
    } alu_op_t;

    // msb first: op, src0, src1, dst, wb
    typedef struct packed {
        alu_op_t                    op;
        logic [`REG_ADDR_WIDTH-1:0] src0;
        logic [`REG_ADDR_WIDTH-1:0] src1;
        logic [`REG_ADDR_WIDTH-1:0] dst;
        logic                       wb;
    } inst_t;

endpackage

// ==== design/data_mem.sv ====
`timescale 1ns/1ps
`include "cpe_consts.svh"

module data_mem (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       ld_en,
    input  logic [`REG_ADDR_WIDTH-1:0] ld_addr,
    input  cpe_pkg::cplx_t             ld_data,
    input  logic                       wb_en,
    input  logic [`REG_ADDR_WIDTH-1:0] wb_addr,
    input  cpe_pkg::cplx_t             wb_data,
    input  logic                       rden,
    input  logic [`REG_ADDR_WIDTH-1:0] raddr0,
    input  logic [`REG_ADDR_WIDTH-1:0] raddr1,
    output cpe_pkg::cplx_t             rdata0,
    output cpe_pkg::cplx_t             rdata1
);
    import cpe_pkg::*;

    cplx_t                      regs [`REG_NUM];
    logic                       we;
    logic [`REG_ADDR_WIDTH-1:0] waddr;
    cplx_t                      wdata;

    ////////////////////////////////////////
    // write port
    ////////////////////////////////////////

    // block load beats write-back
    assign we    = ld_en | wb_en;
    assign waddr = ld_en ? ld_addr : wb_addr;
    assign wdata = ld_en ? ld_data : wb_data;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `REG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[waddr] <= wdata;
        end
    end

    ////////////////////////////////////////
    // read ports
    ////////////////////////////////////////

    // same-edge write not visible, old value read
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rdata0 <= '0;
            rdata1 <= '0;
        end else if (rden) begin
            rdata0 <= regs[raddr0];
            rdata1 <= regs[raddr1];
        end
    end

endmodule

// ==== design/inst_mem.sv ====
`timescale 1ns/1ps
`include "cpe_consts.svh"

module inst_mem (
    input  logic           clk,
    input  logic           arst_n,
    input  logic           inst_in_v,
    input  cpe_pkg::inst_t inst_in,
    input  logic           start,
    output logic           inst_out_v,
    output cpe_pkg::inst_t inst_out
);
    import cpe_pkg::*;

    // raw program words
    logic [`INST_WIDTH-1:0]      imem [`INST_NUM];
    logic [`INST_ADDR_WIDTH-1:0] ld_ptr;
    logic [`INST_ADDR_WIDTH-1:0] pc;
    logic                        running;
    logic                        issue;
    logic                        pc_last;

    // a start while running falls into running anyway
    assign issue   = running | start;
    assign pc_last = (pc == `INST_ADDR_WIDTH'(`INST_NUM - 1));

    ////////////////////////////////////////
    // program load
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (inst_in_v) begin
            imem[ld_ptr] <= inst_in;
        end
    end

    // sequential pointer, wraps after INST_NUM words
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ld_ptr <= '0;
        end else if (inst_in_v) begin
            if (ld_ptr == `INST_ADDR_WIDTH'(`INST_NUM - 1)) begin
                ld_ptr <= '0;
            end else begin
                ld_ptr <= ld_ptr + 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // program run
    ////////////////////////////////////////

    // one pass, one word per cycle, registered read
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            running    <= 1'b0;
            pc         <= '0;
            inst_out_v <= 1'b0;
            inst_out   <= '0;
        end else begin
            inst_out_v <= issue;
            if (issue) begin
                inst_out <= inst_t'(imem[pc]);
                // back to entry 0 after the last word
                pc       <= pc_last ? '0 : pc + 1'b1;
                running  <= !pc_last;
            end
        end
    end

endmodule

// ==== design/pe.sv ====
`timescale 1ns/1ps
`include "cpe_consts.svh"

module pe (
    input  logic           clk,
    input  logic           arst_n,
    input  logic           din_v,
    input  cpe_pkg::cplx_t din_pe,
    input  logic           inst_in_v,
    input  cpe_pkg::inst_t inst_in,
    output logic           dout_v,
    output cpe_pkg::cplx_t dout_pe,
    output cpe_pkg::cplx_t dout_fwd
);
    import cpe_pkg::*;

    // block load
    logic [`REG_ADDR_WIDTH-1:0] ld_cnt;
    logic                       ld_wrap;
    logic                       start;

    // issue and control
    logic                       inst_out_v;
    inst_t                      inst_out;
    logic                       rden;
    logic [`REG_ADDR_WIDTH-1:0] raddr0;
    logic [`REG_ADDR_WIDTH-1:0] raddr1;
    alu_op_t                    op;
    logic                       wb_en;
    logic [`REG_ADDR_WIDTH-1:0] wb_addr;

    // read data into the alu
    cplx_t                      rdata0;
    cplx_t                      rdata1;

    ////////////////////////////////////////
    // load counter and forward
    ////////////////////////////////////////

    // last word of the block being accepted
    assign ld_wrap = din_v & (ld_cnt == `REG_ADDR_WIDTH'(`REG_NUM - 1));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ld_cnt   <= '0;
            start    <= 1'b0;
            dout_fwd <= '0;
        end else begin
            // one-cycle pulse after the block completes
            start <= ld_wrap;
            if (din_v) begin
                ld_cnt <= ld_wrap ? '0 : ld_cnt + 1'b1;
            end
            // last word goes on to the next pe
            if (ld_wrap) begin
                dout_fwd <= din_pe;
            end
        end
    end

    ////////////////////////////////////////
    // instances
    ////////////////////////////////////////

    inst_mem u_inst_mem (
        .clk        (clk),
        .arst_n     (arst_n),
        .inst_in_v  (inst_in_v),
        .inst_in    (inst_in),
        .start      (start),
        .inst_out_v (inst_out_v),
        .inst_out   (inst_out)
    );

    pe_control u_pe_control (
        .clk        (clk),
        .arst_n     (arst_n),
        .inst_out_v (inst_out_v),
        .inst_out   (inst_out),
        .rden       (rden),
        .raddr0     (raddr0),
        .raddr1     (raddr1),
        .op         (op),
        .wb_en      (wb_en),
        .wb_addr    (wb_addr),
        .dout_v     (dout_v)
    );

    // load stream straight in, result back as write-back data
    data_mem u_data_mem (
        .clk     (clk),
        .arst_n  (arst_n),
        .ld_en   (din_v),
        .ld_addr (ld_cnt),
        .ld_data (din_pe),
        .wb_en   (wb_en),
        .wb_addr (wb_addr),
        .wb_data (dout_pe),
        .rden    (rden),
        .raddr0  (raddr0),
        .raddr1  (raddr1),
        .rdata0  (rdata0),
        .rdata1  (rdata1)
    );

    complex_alu u_complex_alu (
        .clk    (clk),
        .arst_n (arst_n),
        .op     (op),
        .din_1  (rdata0),
        .din_2  (rdata1),
        .dout   (dout_pe)
    );

endmodule

// ==== design/pe_control.sv ====
`timescale 1ns/1ps
`include "cpe_consts.svh"

module pe_control (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       inst_out_v,
    input  cpe_pkg::inst_t             inst_out,
    output logic                       rden,
    output logic [`REG_ADDR_WIDTH-1:0] raddr0,
    output logic [`REG_ADDR_WIDTH-1:0] raddr1,
    output cpe_pkg::alu_op_t           op,
    output logic                       wb_en,
    output logic [`REG_ADDR_WIDTH-1:0] wb_addr,
    output logic                       dout_v
);
    import cpe_pkg::*;

    // tag stage that meets rdata at the alu input
    localparam int RD_STAGE = 1;
    // tag stage that meets the alu result
    localparam int LAST     = `PE_LATENCY - 1;

    // decoded fields of the issued word
    alu_op_t                    dec_op;
    logic [`REG_ADDR_WIDTH-1:0] dec_dst;
    logic                       dec_wb;

    // tag pipeline, index k is k+1 cycles after issue
    logic [`PE_LATENCY-1:0]     vld_q;
    logic [`PE_LATENCY-1:0]     wb_q;
    alu_op_t                    op_q  [RD_STAGE+1];
    logic [`REG_ADDR_WIDTH-1:0] dst_q [`PE_LATENCY];

    assign dec_op  = inst_out.op;
    assign dec_dst = inst_out.dst;
    // write-back only for a real issue slot
    assign dec_wb  = inst_out_v & inst_out.wb;

    ////////////////////////////////////////
    // read request
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            raddr0 <= '0;
            raddr1 <= '0;
        end else if (inst_out_v) begin
            raddr0 <= inst_out.src0;
            raddr1 <= inst_out.src1;
        end
    end

    ////////////////////////////////////////
    // tag pipeline
    ////////////////////////////////////////

    // several instructions in flight, shifts every cycle
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            vld_q <= '0;
            wb_q  <= '0;
            for (int i = 0; i <= RD_STAGE; i++) begin
                op_q[i] <= op_add;
            end
            for (int i = 0; i < `PE_LATENCY; i++) begin
                dst_q[i] <= '0;
            end
        end else begin
            vld_q    <= {vld_q[LAST-1:0], inst_out_v};
            wb_q     <= {wb_q[LAST-1:0], dec_wb};
            op_q[0]  <= dec_op;
            dst_q[0] <= dec_dst;
            for (int i = 1; i <= RD_STAGE; i++) begin
                op_q[i] <= op_q[i-1];
            end
            for (int i = 1; i < `PE_LATENCY; i++) begin
                dst_q[i] <= dst_q[i-1];
            end
        end
    end

    // read fires one cycle after issue
    assign rden    = vld_q[0];
    assign op      = op_q[RD_STAGE];
    assign dout_v  = vld_q[LAST];
    assign wb_en   = wb_q[LAST];
    assign wb_addr = dst_q[LAST];

endmodule

// ==== include/cpe_consts.svh ====
`ifndef CPE_CONSTS_SVH
`define CPE_CONSTS_SVH

////////////////////////////////////////
// datapath
////////////////////////////////////////

// width of one half, re or im
`define DATA_WIDTH      16
// fixed point q1.14, product realigned by this
`define FRAC_BITS       14

////////////////////////////////////////
// storage
////////////////////////////////////////

// data block length = data memory depth
`define REG_NUM         8
`define REG_ADDR_WIDTH  3
// program length
`define INST_NUM        8
`define INST_ADDR_WIDTH 3
// op + src0 + src1 + dst + wb
`define INST_WIDTH      12

// issue to result, in cycles
`define PE_LATENCY      4

`endif

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the pe testbench with Verilator, run it, then look for the pass line

cd "$(dirname "$0")" || exit 1

log=sim.log

{ verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module pe_tb -f cpe.f \
    && ./obj_dir/Vpe_tb; } > "$log" 2>&1

cat "$log"

grep -qx "Simulation passed" "$log" && exit 0 \
    || { echo "run failed, see $log"; exit 1; }

// ==== testbench/pe_assertions.sv ====
`timescale 1ns/1ps
`include "cpe_consts.svh"

module pe_assertions (
    input logic clk,
    input logic arst_n,
    input logic start,
    input logic inst_out_v,
    input logic dout_v
);

    // length of the current issue run
    logic [4:0] run_len;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            run_len <= '0;
        end else if (inst_out_v) begin
            run_len <= run_len + 1'b1;
        end else begin
            run_len <= '0;
        end
    end

    ////////////////////////////////////////
    // top-level timing
    ////////////////////////////////////////

    // each result traces back to one issue slot
    a_dout_from_issue: assert property (
        @(posedge clk) disable iff (!arst_n)
        dout_v |-> $past(inst_out_v, `PE_LATENCY)
    ) else $error("dout_v high without an issue %0d cycles earlier", `PE_LATENCY);

    // run just ended, count must be the full program
    a_run_length: assert property (
        @(posedge clk) disable iff (!arst_n)
        (!inst_out_v && run_len != 5'd0) |-> (run_len == 5'(`INST_NUM))
    ) else $error("issue run of %0d cycles, expected %0d", run_len, `INST_NUM);

    // one-cycle start
    a_start_pulse: assert property (
        @(posedge clk) disable iff (!arst_n)
        start |=> !start
    ) else $error("start held high for more than one cycle");

    // no result in the first cycle out of reset
    a_reset_quiet: assert property (
        @(posedge clk) $rose(arst_n) |-> !dout_v
    ) else $error("dout_v high in the first cycle after reset");

endmodule

bind pe pe_assertions u_pe_assertions (
    .clk        (clk),
    .arst_n     (arst_n),
    .start      (start),
    .inst_out_v (inst_out_v),
    .dout_v     (dout_v)
);

// ==== testbench/pe_tb.sv ====
`timescale 1ns/1ps
`include "cpe_consts.svh"

module pe_tb;
    import cpe_pkg::*;

    // cycles allowed for any single wait
    localparam int WAIT_LIMIT = 64;

    logic  clk;
    logic  arst_n;
    logic  din_v;
    cplx_t din_pe;
    logic  inst_in_v;
    inst_t inst_in;
    logic  dout_v;
    cplx_t dout_pe;
    cplx_t dout_fwd;

    // stimulus state and reference model
    logic [31:0] lfsr;
    inst_t       prog [`INST_NUM];
    cplx_t       model_mem [`REG_NUM];
    cplx_t       last_word;
    cplx_t       exp_q [$];

    pe i_pe (
        .clk       (clk),
        .arst_n    (arst_n),
        .din_v     (din_v),
        .din_pe    (din_pe),
        .inst_in_v (inst_in_v),
        .inst_in   (inst_in),
        .dout_v    (dout_v),
        .dout_pe   (dout_pe),
        .dout_fwd  (dout_fwd)
    );

    // 10 ns clock
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    ////////////////////////////////////////
    // reporting
    ////////////////////////////////////////

    task automatic stop_run();
        $display("Simulation failed");
        $fatal(1, "testbench stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] act,
                               input logic [31:0] exp);
        assert (act === exp) else begin
            $display("** Error at %0t: %s is %h, expected %h", $time, name, act, exp);
            stop_run();
        end
    endtask

    ////////////////////////////////////////
    // random source
    ////////////////////////////////////////

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one step per bit taken
    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    ////////////////////////////////////////
    // reference model
    ////////////////////////////////////////

    function automatic cplx_t ref_alu(input alu_op_t op, input cplx_t a, input cplx_t b);
        cplx_t  r;
        longint re_p;
        longint im_p;
        // exact products, no overflow in 64 bits
        re_p = longint'(a.re) * longint'(b.re) - longint'(a.im) * longint'(b.im);
        im_p = longint'(a.re) * longint'(b.im) + longint'(a.im) * longint'(b.re);
        case (op)
            op_add: begin
                r.re = a.re + b.re;
                r.im = a.im + b.im;
            end
            op_sub: begin
                r.re = a.re - b.re;
                r.im = a.im - b.im;
            end
            op_mul: begin
                // shift then keep the low half
                r.re = `DATA_WIDTH'(re_p >>> `FRAC_BITS);
                r.im = `DATA_WIDTH'(im_p >>> `FRAC_BITS);
            end
            default: r = a;
        endcase
        return r;
    endfunction

    // program order, write-back included
    task automatic run_model();
        cplx_t res;
        for (int k = 0; k < `INST_NUM; k++) begin
            res = ref_alu(prog[k].op, model_mem[prog[k].src0], model_mem[prog[k].src1]);
            exp_q.push_back(res);
            if (prog[k].wb) begin
                model_mem[prog[k].dst] = res;
            end
        end
    endtask

    ////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////

    // no source reads a dst written within four slots
    task automatic set_program(input int which);
        if (which == 0) begin
            // add sub mov, r6 and r7 read back five slots later
            prog[0] = '{op_add, 3'd0, 3'd1, 3'd6, 1'b1};
            prog[1] = '{op_sub, 3'd1, 3'd0, 3'd7, 1'b1};
            prog[2] = '{op_add, 3'd2, 3'd3, 3'd0, 1'b0};
            prog[3] = '{op_mov, 3'd4, 3'd5, 3'd0, 1'b0};
            prog[4] = '{op_sub, 3'd5, 3'd2, 3'd0, 1'b0};
            prog[5] = '{op_add, 3'd6, 3'd3, 3'd0, 1'b0};
            prog[6] = '{op_sub, 3'd7, 3'd6, 3'd0, 1'b0};
            prog[7] = '{op_mov, 3'd6, 3'd1, 3'd2, 1'b1};
        end else begin
            // mostly mul, r7 product reused at slot 5
            prog[0] = '{op_mul, 3'd0, 3'd1, 3'd7, 1'b1};
            prog[1] = '{op_mul, 3'd2, 3'd3, 3'd0, 1'b0};
            prog[2] = '{op_mul, 3'd4, 3'd5, 3'd0, 1'b0};
            prog[3] = '{op_mul, 3'd6, 3'd0, 3'd0, 1'b0};
            prog[4] = '{op_mul, 3'd1, 3'd1, 3'd0, 1'b0};
            prog[5] = '{op_mul, 3'd7, 3'd2, 3'd0, 1'b0};
            prog[6] = '{op_mul, 3'd3, 3'd4, 3'd0, 1'b1};
            prog[7] = '{op_sub, 3'd7, 3'd5, 3'd1, 1'b0};
        end
    endtask

    task automatic load_program();
        for (int k = 0; k < `INST_NUM; k++) begin
            @(posedge clk);
            inst_in_v <= 1'b1;
            inst_in   <= prog[k];
        end
        @(posedge clk);
        inst_in_v <= 1'b0;
    endtask

    task automatic load_block(input logic edge_words);
        logic [31:0] bits;
        for (int k = 0; k < `REG_NUM; k++) begin
            take_bits(32, bits);
            // words 0 and 1 overflow both halves when added
            if (edge_words && k == 0) begin
                bits = 32'h7fff_8001;
            end else if (edge_words && k == 1) begin
                bits = 32'h0102_fffe;
            end
            model_mem[k] = cplx_t'(bits);
            @(posedge clk);
            din_v  <= 1'b1;
            din_pe <= cplx_t'(bits);
        end
        last_word = cplx_t'(bits);
        @(posedge clk);
        din_v <= 1'b0;
    endtask

    ////////////////////////////////////////
    // result collection
    ////////////////////////////////////////

    // sampled at the falling edge
    task automatic collect_run(input int run);
        cplx_t exp_word;
        int    waited;
        for (int n = 0; n < `INST_NUM; n++) begin
            waited = 0;
            @(negedge clk);
            while (!dout_v && waited < WAIT_LIMIT) begin
                @(negedge clk);
                waited++;
            end
            if (!dout_v) begin
                $display("timeout waiting for result %0d of run %0d", n, run);
                stop_run();
            end
            exp_word = exp_q.pop_front();
            check_value("dout_pe", dout_pe, exp_word);
            check_value("dout_fwd", dout_fwd, last_word);
        end
        // nothing beyond INST_NUM results
        @(negedge clk);
        check_value("dout_v", 32'(dout_v), 32'd0);
    endtask

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////

    initial begin
        arst_n    = 1'b0;
        din_v     = 1'b0;
        din_pe    = '0;
        inst_in_v = 1'b0;
        inst_in   = '0;
        lfsr      = 32'h9c40;
        repeat (10) @(posedge clk);
        arst_n <= 1'b1;
        // outputs still at reset values
        @(negedge clk);
        check_value("dout_v", 32'(dout_v), 32'd0);
        check_value("dout_pe", dout_pe, 32'd0);
        check_value("dout_fwd", dout_fwd, 32'd0);
        // programs alternate, each reloaded with a new block
        for (int run = 0; run < 4; run++) begin
            set_program(run % 2);
            load_program();
            load_block(run == 0);
            run_model();
            collect_run(run);
        end
        $display("Simulation passed");
        $finish;
    end

endmodule
